//--- include/spi_defines.svh
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// widest character the shift engine handles
`define SPI_CHAR_NBITS 16

// half-period divider in system clocks minus one
`define SPI_DIV_NBITS 8

// character length field holds bits minus one
`define SPI_LEN_NBITS 4

`endif

//--- source/spi_pkg.sv
`include "spi_defines.svh"

package spi_pkg;

    // per-frame settings latched by the controller
    typedef struct packed {
        logic                      cpol;      // sck idle level
        logic                      cpha;      // 0 samples on leading edge
        logic                      tx_only;   // keep last rchar
        logic                      loop;      // sample mosi instead of miso
        logic                      rev;       // 1 sends lsb first
        logic [`SPI_LEN_NBITS-1:0] char_len;  // bits minus one
        logic [`SPI_DIV_NBITS-1:0] ndivider;  // half-period minus one
    } spi_cfg_t;

    typedef struct packed {
        spi_cfg_t                   cfg;
        logic [`SPI_CHAR_NBITS-1:0] wchar;   // right-aligned
    } spi_req_t;

    typedef struct packed {
        logic [`SPI_CHAR_NBITS-1:0] rchar;   // right-aligned with upper bits zero
    } spi_rsp_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LAUNCH,
        CTRL_SHIFT,
        CTRL_ACK
    } ctrl_state_e;

    // high and low are relative to cpol so high_half is the active level
    typedef enum logic [1:0] {
        SCK_IDLE,
        SCK_HIGH_HALF,
        SCK_LOW_HALF
    } sck_state_e;

endpackage

//--- source/spi_clk_gen.sv
`include "spi_defines.svh"

module spi_clk_gen
(
    input  logic              S_CHAR_GO,
    input  logic              S_RESETN,
    input  logic              char_go,
    input  spi_pkg::spi_cfg_t cfg,
    output logic              sck,
    output logic              lead_edge,
    output logic              trail_edge,
    output logic              frame_end
);

    import spi_pkg::*;

    sck_state_e                state;
    logic                      go_q;
    logic                      tick;
    logic                      last_period;
    logic [`SPI_DIV_NBITS-1:0] div_cnt;
    logic [`SPI_LEN_NBITS-1:0] per_cnt;

    assign tick        = (div_cnt == cfg.ndivider);     // half period elapsed
    assign last_period = (per_cnt == cfg.char_len);

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            state      <= SCK_IDLE;
            go_q       <= 1'b0;
            div_cnt    <= '0;
            per_cnt    <= '0;
            sck        <= 1'b0;
            lead_edge  <= 1'b0;
            trail_edge <= 1'b0;
            frame_end  <= 1'b0;
        end
        else
        begin
            go_q       <= char_go;
            lead_edge  <= 1'b0;
            trail_edge <= 1'b0;
            frame_end  <= 1'b0;
            case (state)
                SCK_IDLE:
                begin
                    sck     <= cfg.cpol;    // rest at idle level
                    div_cnt <= '0;
                    per_cnt <= '0;
                    if (char_go && !go_q)
                        state <= SCK_LOW_HALF;
                end
                SCK_LOW_HALF:
                begin
                    if (tick)
                    begin
                        div_cnt   <= '0;
                        sck       <= ~cfg.cpol;
                        lead_edge <= 1'b1;
                        state     <= SCK_HIGH_HALF;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                SCK_HIGH_HALF:
                begin
                    if (tick)
                    begin
                        div_cnt    <= '0;
                        sck        <= cfg.cpol;
                        trail_edge <= 1'b1;
                        if (last_period)
                        begin
                            frame_end <= 1'b1;  // with the last trailing strobe
                            state     <= SCK_IDLE;
                        end
                        else
                        begin
                            per_cnt <= per_cnt + 1'b1;
                            state   <= SCK_LOW_HALF;
                        end
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                default:
                    state <= SCK_IDLE;
            endcase
        end
    end

endmodule

//--- source/spi_trx_one_char.sv
`include "spi_defines.svh"

module spi_trx_one_char
(
    input  logic                       S_CHAR_GO,
    input  logic                       S_RESETN,
    input  logic                       char_go,
    input  spi_pkg::spi_cfg_t          cfg,
    input  logic [`SPI_CHAR_NBITS-1:0] wchar,
    input  logic                       lead_edge,
    input  logic                       trail_edge,
    input  logic                       frame_end,
    output logic                       mosi,
    input  logic                       miso,
    output logic                       char_done,
    output logic [`SPI_CHAR_NBITS-1:0] rchar
);

    logic                       go_q;
    logic                       start;
    logic                       sample_stb;
    logic                       shift_stb;
    logic                       rx_bit;
    logic [`SPI_LEN_NBITS-1:0]  bit_idx;
    logic [`SPI_LEN_NBITS-1:0]  first_idx;
    logic [`SPI_LEN_NBITS-1:0]  next_idx;
    logic [`SPI_CHAR_NBITS-1:0] shift_rx;
    logic [`SPI_CHAR_NBITS-1:0] rx_next;

    assign start      = char_go & ~go_q;
    assign sample_stb = cfg.cpha ? trail_edge : lead_edge;
    assign shift_stb  = cfg.cpha ? lead_edge : trail_edge;
    assign rx_bit     = cfg.loop ? mosi : miso;     // internal loopback
    assign first_idx  = cfg.rev ? '0 : cfg.char_len;
    assign next_idx   = cfg.rev ? bit_idx + 1'b1 : bit_idx - 1'b1;

    // sampled bit lands at the same index it was sent from
    always_comb
    begin
        rx_next = shift_rx;
        if (sample_stb)
            rx_next[bit_idx] = rx_bit;
    end

    // transmit side and bit index
    always_ff @(posedge S_CHAR_GO or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            go_q    <= 1'b0;
            bit_idx <= '0;
            mosi    <= 1'b0;
        end
        else
        begin
            go_q <= char_go;
            if (start)
            begin
                bit_idx <= first_idx;
                if (!cfg.cpha)
                    mosi <= wchar[first_idx];   // cpha 0 presents before first edge
            end
            else
            begin
                // cpha 1 drives the current bit while cpha 0 moves on to the next one
                if (shift_stb && !frame_end)
                    mosi <= cfg.cpha ? wchar[bit_idx] : wchar[next_idx];
                if (trail_edge && !frame_end)
                    bit_idx <= next_idx;
            end
        end
    end

    // cleared at frame start so bits above char_len stay zero
    always_ff @(posedge S_CHAR_GO)
    begin
        if (start)
            shift_rx <= '0;
        else
            shift_rx <= rx_next;
    end

    // done one cycle after the frame closes for either phase
    always_ff @(posedge S_CHAR_GO or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            char_done <= 1'b0;
            rchar     <= '0;
        end
        else
        begin
            char_done <= frame_end;
            if (frame_end && !cfg.tx_only)
                rchar <= rx_next;           // includes a last cpha 1 sample
        end
    end

endmodule

//--- source/spi_char_ctrl.sv
`include "spi_defines.svh"

module spi_char_ctrl
(
    input  logic                       S_CHAR_GO,
    input  logic                       S_RESETN,
    input  logic                       req,
    input  spi_pkg::spi_req_t          req_data,
    output logic                       ack,
    output spi_pkg::spi_rsp_t          rsp,
    output logic                       char_go,
    output spi_pkg::spi_cfg_t          cfg,
    output logic [`SPI_CHAR_NBITS-1:0] wchar,
    input  logic                       char_done,
    input  logic [`SPI_CHAR_NBITS-1:0] rchar
);

    import spi_pkg::*;

    ctrl_state_e state;
    logic        accept;

    assign accept = (state == CTRL_IDLE) && req;

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN)
    begin
        if (!S_RESETN)
        begin
            state   <= CTRL_IDLE;
            ack     <= 1'b0;
            char_go <= 1'b0;
            cfg     <= '0;      // sck idles low out of reset
            rsp     <= '0;
        end
        else
        begin
            case (state)
                CTRL_IDLE:
                begin
                    if (accept)
                    begin
                        cfg     <= req_data.cfg;
                        char_go <= 1'b1;
                        state   <= CTRL_LAUNCH;
                    end
                end
                CTRL_LAUNCH:
                    state <= CTRL_SHIFT;        // char_go rising seen downstream
                CTRL_SHIFT:
                begin
                    if (char_done)
                    begin
                        char_go   <= 1'b0;
                        ack       <= 1'b1;
                        rsp.rchar <= rchar;
                        state     <= CTRL_ACK;
                    end
                end
                CTRL_ACK:
                begin
                    // hold rsp until the host lets go of req
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= CTRL_IDLE;
                    end
                end
                default:
                    state <= CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_CHAR_GO)
    begin
        if (accept)
            wchar <= req_data.wchar;
    end

endmodule

//--- source/spi_master_top.sv
`include "spi_defines.svh"

module spi_master_top
(
    input  logic              S_CHAR_GO,
    input  logic              S_RESETN,
    input  logic              req,
    input  spi_pkg::spi_req_t req_data,
    output logic              ack,
    output spi_pkg::spi_rsp_t rsp,
    output logic              sck,
    output logic              mosi,
    input  logic              miso
);

    import spi_pkg::*;

    logic                       char_go;
    logic                       char_done;
    logic                       lead_edge;
    logic                       trail_edge;
    logic                       frame_end;
    spi_cfg_t                   cfg;
    logic [`SPI_CHAR_NBITS-1:0] wchar;
    logic [`SPI_CHAR_NBITS-1:0] rchar;

    spi_char_ctrl u_char_ctrl
    (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rsp       (rsp),
        .char_go   (char_go),
        .cfg       (cfg),
        .wchar     (wchar),
        .char_done (char_done),
        .rchar     (rchar)
    );

    spi_clk_gen u_clk_gen
    (
        .S_CHAR_GO  (S_CHAR_GO),
        .S_RESETN   (S_RESETN),
        .char_go    (char_go),
        .cfg        (cfg),
        .sck        (sck),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .frame_end  (frame_end)
    );

    spi_trx_one_char u_trx
    (
        .S_CHAR_GO  (S_CHAR_GO),
        .S_RESETN   (S_RESETN),
        .char_go    (char_go),
        .cfg        (cfg),
        .wchar      (wchar),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .frame_end  (frame_end),
        .mosi       (mosi),
        .miso       (miso),
        .char_done  (char_done),
        .rchar      (rchar)
    );

endmodule

//--- verif/spi_master_tb.sv
`include "spi_defines.svh"

module spi_master_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import spi_pkg::*;

    localparam int NUM_TESTS    = 40;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = NUM_TESTS * (2 * 16 * 8 + 20) + RESET_CYCLES + 2;

    logic     S_CHAR_GO;
    logic     S_RESETN;
    logic     req;
    spi_req_t req_data;
    logic     ack;
    spi_rsp_t rsp;
    logic     sck;
    logic     mosi;
    logic     miso;

    integer                     seed;
    int                         errors;
    int                         tests_run;
    int                         tests_bad;
    int                         cycle_cnt = 0;
    spi_cfg_t                   cur_cfg;            // frame the slave model follows
    spi_rsp_t                   prev_rsp;
    logic [`SPI_CHAR_NBITS-1:0] slave_char;
    logic [`SPI_CHAR_NBITS-1:0] mosi_cap;
    int                         lead_cnt;
    int                         trail_cnt;
    logic                       sck_prev;

    spi_master_top DUT
    (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rsp       (rsp),
        .sck       (sck),
        .mosi      (mosi),
        .miso      (miso)
    );

    always #10 S_CHAR_GO = ~S_CHAR_GO;

    always @(posedge S_CHAR_GO)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: the DUT did not finish its frames within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // position k of the frame maps to a character bit by order
    function automatic int bit_pos(input spi_cfg_t cfg, input int k);
        if (cfg.rev)
            return k;
        return int'(cfg.char_len) - k;
    endfunction

    function automatic logic [`SPI_CHAR_NBITS-1:0] len_mask(input spi_cfg_t cfg);
        logic [`SPI_CHAR_NBITS-1:0] m;
        m = '0;
        for (int i = 0; i <= int'(cfg.char_len); i++)
            m[i] = 1'b1;
        return m;
    endfunction

    // SPI slave reacting to sck a little after the system clock edge
    always @(posedge S_CHAR_GO)
    begin
        #2;
        if (S_RESETN && sck !== sck_prev)
        begin
            if (sck !== cur_cfg.cpol)
            begin
                if (cur_cfg.cpha)
                    miso = slave_char[bit_pos(cur_cfg, lead_cnt)];     // shift on leading
                else
                    mosi_cap[bit_pos(cur_cfg, lead_cnt)] = mosi;       // sample on leading
                lead_cnt++;
            end
            else if (lead_cnt > trail_cnt)                             // skips cpol change
            begin
                if (cur_cfg.cpha)
                    mosi_cap[bit_pos(cur_cfg, trail_cnt)] = mosi;
                else if (trail_cnt < int'(cur_cfg.char_len))
                    miso = slave_char[bit_pos(cur_cfg, trail_cnt + 1)];
                trail_cnt++;
            end
        end
        sck_prev = sck;
    end

    task automatic compare_rsp(input spi_rsp_t got, input spi_rsp_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0d ns: %s rchar is %h, expected %h",
                     $time, what, got.rchar, exp.rchar);
        end
    endtask

    task automatic verify_char(input logic [`SPI_CHAR_NBITS-1:0] got,
                               input logic [`SPI_CHAR_NBITS-1:0] exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_level(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic make_request(input int n, output spi_req_t r);
        logic [31:0] rnd;
        rnd              = $random(seed);
        r.cfg.cpol       = rnd[0];
        r.cfg.cpha       = rnd[1];
        r.cfg.rev        = rnd[2];
        r.cfg.loop       = rnd[3];
        r.cfg.tx_only    = (rnd[5:4] == 2'b00);     // about one frame in four
        r.cfg.char_len   = rnd[11:8];
        r.cfg.ndivider   = '0;
        r.cfg.ndivider[2:0] = rnd[14:12];
        rnd              = $random(seed);
        r.wchar          = rnd[`SPI_CHAR_NBITS-1:0];
        if (n < 8)
        begin
            // sweep all modes and both orders against the slave first
            r.cfg.cpol    = n[0];
            r.cfg.cpha    = n[1];
            r.cfg.rev     = n[2];
            r.cfg.loop    = 1'b0;
            r.cfg.tx_only = 1'b0;
        end
    endtask

    task automatic wait_ack();
        do
        begin
            @(posedge S_CHAR_GO);
            #2;
        end
        while (ack !== 1'b1);
    endtask

    task automatic run_frame(input int n);
        spi_req_t                   r;
        spi_rsp_t                   exp;
        logic [`SPI_CHAR_NBITS-1:0] mask;
        logic [31:0]                rnd;
        int                         hold;
        int                         errs_before;
        errs_before = errors;
        make_request(n, r);
        mask        = len_mask(r.cfg);
        rnd         = $random(seed);
        slave_char  = rnd[`SPI_CHAR_NBITS-1:0];
        hold        = rnd[17:16];                   // extra cycles req stays up
        cur_cfg     = r.cfg;
        lead_cnt    = 0;
        trail_cnt   = 0;
        mosi_cap    = '0;
        miso        = r.cfg.cpha ? 1'b0 : slave_char[bit_pos(r.cfg, 0)];
        if (r.cfg.tx_only)
            exp = prev_rsp;
        else if (r.cfg.loop)
            exp.rchar = r.wchar & mask;
        else
            exp.rchar = slave_char & mask;
        req_data = r;
        req      = 1'b1;
        wait_ack();
        compare_rsp(rsp, exp, "response");
        verify_char(mosi_cap, r.wchar & mask, "mosi stream");
        if (lead_cnt != int'(r.cfg.char_len) + 1 || trail_cnt != lead_cnt)
        begin
            errors++;
            $display("FAILED at %0d ns: %0d leading and %0d trailing sck edges, expected %0d",
                     $time, lead_cnt, trail_cnt, int'(r.cfg.char_len) + 1);
        end
        repeat (hold)
        begin
            @(posedge S_CHAR_GO);
            #2;
            expect_level(ack, 1'b1, "ack with req held");
            compare_rsp(rsp, exp, "held response");
        end
        req = 1'b0;
        @(posedge S_CHAR_GO);
        #2;
        expect_level(ack, 1'b0, "ack after req fell");
        expect_level(sck, r.cfg.cpol, "sck idle level");
        prev_rsp = exp;
        tests_run++;
        if (errors != errs_before)
            tests_bad++;
        $display("test %0d: cpol %0d cpha %0d rev %0d len %0d div %0d loop %0d tx_only %0d : %s",
                 n + 1, r.cfg.cpol, r.cfg.cpha, r.cfg.rev, r.cfg.char_len + 1, r.cfg.ndivider,
                 r.cfg.loop, r.cfg.tx_only, (errors == errs_before) ? "ok" : "error");
    endtask

    initial
    begin
        int reset_errs;
        seed       = 32'h0dff108a;
        S_CHAR_GO  = 1'b0;
        S_RESETN   = 1'b0;
        req        = 1'b0;
        req_data   = '0;
        miso       = 1'b0;
        cur_cfg    = '0;
        prev_rsp   = '0;
        slave_char = '0;
        mosi_cap   = '0;
        lead_cnt   = 0;
        trail_cnt  = 0;
        sck_prev   = 1'b0;
        errors     = 0;
        tests_run  = 0;
        tests_bad  = 0;
        repeat (RESET_CYCLES) @(posedge S_CHAR_GO);
        #2;
        S_RESETN = 1'b1;
        @(posedge S_CHAR_GO);
        #2;
        reset_errs = errors;
        expect_level(ack, 1'b0, "ack after reset");
        expect_level(mosi, 1'b0, "mosi after reset");
        expect_level(sck, 1'b0, "sck after reset");
        tests_run++;
        if (errors != reset_errs)
            tests_bad++;
        $display("test 0: reset state : %s", (errors == reset_errs) ? "ok" : "error");
        for (int n = 0; n < NUM_TESTS; n++)
            run_frame(n);
        $display("summary: %0d tests, %0d ok, %0d with errors, %0d failed checks",
                 tests_run, tests_run - tests_bad, tests_bad, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
source/spi_pkg.sv
source/spi_clk_gen.sv
source/spi_trx_one_char.sv
source/spi_char_ctrl.sv
source/spi_master_top.sv
verif/spi_master_tb.sv

//--- Bender.yml
package:
  name: spi_master

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/spi_pkg.sv
      - source/spi_clk_gen.sv
      - source/spi_trx_one_char.sv
      - source/spi_char_ctrl.sv
      - source/spi_master_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/spi_master_tb.sv
